// File: switch_defs.svh
`ifndef SWITCH_DEFS_SVH
`define SWITCH_DEFS_SVH

// port count of the switch
`define SW_NUM_PORTS 6

// frame size limits in bytes
`define SW_MIN_FRAME 8
`define SW_MAX_FRAME 64   // also the buffer depth

// upper 40 bits of a local destination 02:00:00:00:00
`define SW_MAC_PREFIX 40'h02_00_00_00_00

// idle cycles on an output between two frames
`define SW_TX_GAP 2

`endif

// File: switch_pkg.sv
`default_nettype none

package switch_pkg;

   // one frame byte and one line nibble
   typedef logic [7:0] byte_t;
   typedef logic [3:0] nibble_t;

   typedef logic [2:0] port_idx_t;   // switch port number
   typedef logic [6:0] frame_len_t;  // byte count up to 64

   typedef logic [47:0] mac_t;

   // ingress buffer FSM
   typedef enum logic [1:0]
   {
      ST_IDLE,   // waiting for a frame start
      ST_RECV,   // writing bytes
      ST_WAIT,   // accepted frame waits for a grant
      ST_SEND    // reading out to the fabric
   } ingr_state_t;

endpackage

`default_nettype wire

// File: port_rx.sv
`timescale 1ns/1ps
`default_nettype none

module port_rx
(
   input  logic                clk,
   input  logic                rst_n_i,
   input  logic                rx_dv_i,
   input  switch_pkg::nibble_t rx_nibble_i,
   output switch_pkg::byte_t   rx_byte_o,
   output logic                rx_byte_vld_o,
   output logic                rx_sof_o,
   output logic                rx_eof_o
);

   logic                phase_q;   // 1 when the high nibble is due
   switch_pkg::nibble_t low_q;
   logic                dv_q;
   logic                first_q;   // next byte is the first of the frame

   // low nibble is held until its partner arrives
   always_ff @(posedge clk)
   begin
      if (rx_dv_i && !phase_q)
         low_q <= rx_nibble_i;
      if (rx_dv_i && phase_q)
         rx_byte_o <= {rx_nibble_i, low_q};
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         phase_q       <= 1'b0;
         dv_q          <= 1'b0;
         first_q       <= 1'b0;
         rx_byte_vld_o <= 1'b0;
         rx_sof_o      <= 1'b0;
         rx_eof_o      <= 1'b0;
      end
      else
      begin
         dv_q          <= rx_dv_i;
         rx_byte_vld_o <= rx_dv_i && phase_q;
         rx_sof_o      <= rx_dv_i && phase_q && first_q;
         rx_eof_o      <= dv_q && !rx_dv_i;           // falling edge of dv
         phase_q       <= rx_dv_i ? !phase_q : 1'b0;  // odd trailing nibble dropped here
         if (rx_dv_i && !dv_q)
            first_q <= 1'b1;                          // rising edge of dv
         else if (rx_dv_i && phase_q)
            first_q <= 1'b0;
      end
   end

   // each byte pairs two nibbles sampled while dv was high
   a_byte_pair: assert property (@(posedge clk) disable iff (!rst_n_i)
      rx_byte_vld_o |-> $past(rx_dv_i) && $past(rx_dv_i, 2));

endmodule

`default_nettype wire

// File: ingress_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "switch_defs.svh"

module ingress_buffer
#(
   parameter int PORT_ID = 0
)
(
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  switch_pkg::byte_t     rx_byte_i,
   input  logic                  rx_byte_vld_i,
   input  logic                  rx_sof_i,
   input  logic                  rx_eof_i,
   input  logic                  fwd_gnt_i,
   output logic                  fwd_req_o,
   output switch_pkg::port_idx_t fwd_port_o,
   output switch_pkg::byte_t     out_byte_o,
   output logic                  out_vld_o,
   output logic                  out_last_o
);

   localparam int AW = $clog2(`SW_MAX_FRAME);

   switch_pkg::byte_t       mem [`SW_MAX_FRAME];
   switch_pkg::ingr_state_t state_q;
   switch_pkg::frame_len_t  len_q;
   switch_pkg::frame_len_t  rd_ptr_q;
   switch_pkg::mac_t        mac_q;
   logic                    too_long_q;   // frame ran past the buffer
   logic                    phase_q;      // read pacing of one byte per 2 cycles

   logic                    wr_en;
   logic [AW-1:0]           wr_addr;
   logic                    rd_en;
   logic                    rd_last;
   logic [7:0]              dst_m1;
   switch_pkg::port_idx_t   dst_port;
   logic                    accept;

   assign wr_en   = rx_byte_vld_i &&
                    ((state_q == switch_pkg::ST_IDLE && rx_sof_i) ||
                     (state_q == switch_pkg::ST_RECV &&
                      len_q < switch_pkg::frame_len_t'(`SW_MAX_FRAME)));
   assign wr_addr = (state_q == switch_pkg::ST_IDLE) ? '0 : len_q[AW-1:0];

   assign rd_en   = (state_q == switch_pkg::ST_SEND) && !phase_q;
   assign rd_last = (rd_ptr_q == len_q - 7'd1);

   // static table sends 02:00:00:00:00:0N to port N-1
   assign dst_m1   = mac_q[7:0] - 8'd1;
   assign dst_port = dst_m1[2:0];
   assign accept   = !too_long_q &&
                     len_q >= switch_pkg::frame_len_t'(`SW_MIN_FRAME) &&
                     mac_q[47:8] == `SW_MAC_PREFIX &&
                     mac_q[7:0] >= 8'd1 &&
                     mac_q[7:0] <= 8'(`SW_NUM_PORTS) &&
                     dst_port != switch_pkg::port_idx_t'(PORT_ID);

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_addr] <= rx_byte_i;
      if (wr_en && (state_q == switch_pkg::ST_IDLE || len_q < 7'd6))
         mac_q <= {mac_q[39:0], rx_byte_i};   // MSB first
      if (rd_en)
         out_byte_o <= mem[rd_ptr_q[AW-1:0]];
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         state_q    <= switch_pkg::ST_IDLE;
         len_q      <= '0;
         rd_ptr_q   <= '0;
         too_long_q <= 1'b0;
         phase_q    <= 1'b0;
         fwd_req_o  <= 1'b0;
         fwd_port_o <= '0;
         out_vld_o  <= 1'b0;
         out_last_o <= 1'b0;
      end
      else
      begin
         out_vld_o  <= 1'b0;
         out_last_o <= 1'b0;
         case (state_q)
            switch_pkg::ST_IDLE:
            begin
               if (rx_sof_i && rx_byte_vld_i)
               begin
                  len_q      <= 7'd1;
                  too_long_q <= 1'b0;
                  state_q    <= switch_pkg::ST_RECV;
               end
            end
            switch_pkg::ST_RECV:
            begin
               if (rx_eof_i)
               begin
                  if (accept)
                  begin
                     fwd_req_o  <= 1'b1;
                     fwd_port_o <= dst_port;
                     state_q    <= switch_pkg::ST_WAIT;
                  end
                  else
                     state_q <= switch_pkg::ST_IDLE;   // dropped
               end
               else if (rx_byte_vld_i)
               begin
                  if (wr_en)
                     len_q <= len_q + 7'd1;
                  else
                     too_long_q <= 1'b1;
               end
            end
            switch_pkg::ST_WAIT:
            begin
               if (fwd_gnt_i)
               begin
                  rd_ptr_q <= '0;
                  phase_q  <= 1'b0;
                  state_q  <= switch_pkg::ST_SEND;
               end
            end
            default:
            begin
               phase_q <= !phase_q;
               if (rd_en)
               begin
                  out_vld_o  <= 1'b1;
                  out_last_o <= rd_last;
                  rd_ptr_q   <= rd_ptr_q + 7'd1;
                  if (rd_last)
                  begin
                     fwd_req_o <= 1'b0;
                     state_q   <= switch_pkg::ST_IDLE;
                  end
               end
            end
         endcase
      end
   end

   // bytes only leave while the fabric holds the grant for this input
   a_vld_in_gnt: assert property (@(posedge clk) disable iff (!rst_n_i)
      out_vld_o |-> fwd_gnt_i);

endmodule

`default_nettype wire

// File: switch_fabric.sv
`timescale 1ns/1ps
`default_nettype none
`include "switch_defs.svh"

module switch_fabric
(
   input  logic                      clk,
   input  logic                      rst_n_i,
   input  logic [`SW_NUM_PORTS-1:0]  fwd_req_i,
   input  switch_pkg::port_idx_t     fwd_port_i [`SW_NUM_PORTS],
   input  switch_pkg::byte_t         out_byte_i [`SW_NUM_PORTS],
   input  logic [`SW_NUM_PORTS-1:0]  out_vld_i,
   input  logic [`SW_NUM_PORTS-1:0]  out_last_i,
   output logic [`SW_NUM_PORTS-1:0]  fwd_gnt_o,
   output switch_pkg::byte_t         tx_byte_o [`SW_NUM_PORTS],
   output logic [`SW_NUM_PORTS-1:0]  tx_byte_vld_o
);

   localparam int N     = `SW_NUM_PORTS;
   localparam int HOLD  = `SW_TX_GAP + 2;   // tx pipeline drains in 2 cycles
   localparam int GAP_W = $clog2(HOLD + 1);

   switch_pkg::port_idx_t rr_ptr_q [N];
   switch_pkg::port_idx_t owner_q  [N];
   logic [N-1:0]          busy_q;
   logic [GAP_W-1:0]      gap_q    [N];

   logic [N-1:0]          win_vld;
   switch_pkg::port_idx_t win_idx  [N];
   logic [N-1:0]          gnt_mat  [N];   // [output][input]
   logic [N-1:0]          gnt_col  [N];   // [input][output]

   // round robin search where the input closest to the pointer wins
   always_comb
   begin
      int idx;
      for (int o = 0; o < N; o++)
      begin
         win_vld[o] = 1'b0;
         win_idx[o] = '0;
         for (int k = N - 1; k >= 0; k--)
         begin
            idx = (int'(rr_ptr_q[o]) + k) % N;
            if (fwd_req_i[idx] && fwd_port_i[idx] == switch_pkg::port_idx_t'(o))
            begin
               win_vld[o] = 1'b1;
               win_idx[o] = switch_pkg::port_idx_t'(idx);
            end
         end
      end
   end

   for (genvar o = 0; o < N; o++)
   begin : g_out
      always_ff @(posedge clk)
      begin
         if (!rst_n_i)
         begin
            rr_ptr_q[o]      <= '0;
            owner_q[o]       <= '0;
            busy_q[o]        <= 1'b0;
            gap_q[o]         <= '0;
            tx_byte_vld_o[o] <= 1'b0;
         end
         else
         begin
            tx_byte_vld_o[o] <= busy_q[o] && out_vld_i[owner_q[o]];
            if (busy_q[o])
            begin
               if (out_vld_i[owner_q[o]] && out_last_i[owner_q[o]])
               begin
                  busy_q[o] <= 1'b0;
                  gap_q[o]  <= GAP_W'(HOLD);
               end
            end
            else if (gap_q[o] != '0)
               gap_q[o] <= gap_q[o] - GAP_W'(1);
            else if (win_vld[o])
            begin
               busy_q[o]   <= 1'b1;
               owner_q[o]  <= win_idx[o];
               rr_ptr_q[o] <= (win_idx[o] == switch_pkg::port_idx_t'(N - 1)) ?
                              '0 : win_idx[o] + 3'd1;
            end
         end
      end

      // one register stage on the byte path
      always_ff @(posedge clk)
         tx_byte_o[o] <= out_byte_i[owner_q[o]];

      for (genvar i = 0; i < N; i++)
      begin : g_in
         assign gnt_mat[o][i] = busy_q[o] && owner_q[o] == switch_pkg::port_idx_t'(i);
         assign gnt_col[i][o] = gnt_mat[o][i];
      end

      // the granted input keeps pointing at this output until it is released
      a_out_owner: assert property (@(posedge clk) disable iff (!rst_n_i)
         busy_q[o] |-> fwd_port_i[owner_q[o]] == switch_pkg::port_idx_t'(o));
   end

   for (genvar i = 0; i < N; i++)
   begin : g_gnt
      assign fwd_gnt_o[i] = |gnt_col[i];

      a_in_one: assert property (@(posedge clk) disable iff (!rst_n_i)
         $onehot0(gnt_col[i]));
   end

endmodule

`default_nettype wire

// File: port_tx.sv
`timescale 1ns/1ps
`default_nettype none

module port_tx
(
   input  logic                clk,
   input  logic                rst_n_i,
   input  switch_pkg::byte_t   tx_byte_i,
   input  logic                tx_byte_vld_i,
   output logic                tx_en_o,
   output switch_pkg::nibble_t tx_nibble_o
);

   switch_pkg::byte_t byte_q;
   logic              busy_q;
   logic              phase_q;   // 0 low nibble, 1 high nibble

   always_ff @(posedge clk)
   begin
      if (tx_byte_vld_i)
         byte_q <= tx_byte_i;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         busy_q  <= 1'b0;
         phase_q <= 1'b0;
      end
      else if (tx_byte_vld_i)
      begin
         busy_q  <= 1'b1;
         phase_q <= 1'b0;
      end
      else if (busy_q && !phase_q)
         phase_q <= 1'b1;
      else
      begin
         busy_q  <= 1'b0;   // pair done with no next byte
         phase_q <= 1'b0;
      end
   end

   assign tx_en_o     = busy_q;
   assign tx_nibble_o = !busy_q ? 4'h0 :
                        phase_q ? byte_q[7:4] : byte_q[3:0];

endmodule

`default_nettype wire

// File: switch_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "switch_defs.svh"

module switch_top
(
   input  logic                      clk,
   input  logic                      rst_n_i,
   input  logic [`SW_NUM_PORTS-1:0]  rx_dv_i,
   input  switch_pkg::nibble_t       rx_nibble_i [`SW_NUM_PORTS],
   output logic [`SW_NUM_PORTS-1:0]  tx_en_o,
   output switch_pkg::nibble_t       tx_nibble_o [`SW_NUM_PORTS]
);

   // receive side
   wire switch_pkg::byte_t     rx_byte     [`SW_NUM_PORTS];
   wire [`SW_NUM_PORTS-1:0]    rx_byte_vld;
   wire [`SW_NUM_PORTS-1:0]    rx_sof;
   wire [`SW_NUM_PORTS-1:0]    rx_eof;

   // buffer to fabric
   wire [`SW_NUM_PORTS-1:0]    fwd_req;
   wire [`SW_NUM_PORTS-1:0]    fwd_gnt;
   wire switch_pkg::port_idx_t fwd_port    [`SW_NUM_PORTS];
   wire switch_pkg::byte_t     out_byte    [`SW_NUM_PORTS];
   wire [`SW_NUM_PORTS-1:0]    out_vld;
   wire [`SW_NUM_PORTS-1:0]    out_last;

   // fabric to transmitters
   wire switch_pkg::byte_t     tx_byte     [`SW_NUM_PORTS];
   wire [`SW_NUM_PORTS-1:0]    tx_byte_vld;

   for (genvar g = 0; g < `SW_NUM_PORTS; g++)
   begin : g_port
      port_rx u_rx
      (
         .clk           (clk),
         .rst_n_i       (rst_n_i),
         .rx_dv_i       (rx_dv_i[g]),
         .rx_nibble_i   (rx_nibble_i[g]),
         .rx_byte_o     (rx_byte[g]),
         .rx_byte_vld_o (rx_byte_vld[g]),
         .rx_sof_o      (rx_sof[g]),
         .rx_eof_o      (rx_eof[g])
      );

      ingress_buffer #(.PORT_ID(g)) u_ibuf
      (
         .clk           (clk),
         .rst_n_i       (rst_n_i),
         .rx_byte_i     (rx_byte[g]),
         .rx_byte_vld_i (rx_byte_vld[g]),
         .rx_sof_i      (rx_sof[g]),
         .rx_eof_i      (rx_eof[g]),
         .fwd_gnt_i     (fwd_gnt[g]),
         .fwd_req_o     (fwd_req[g]),
         .fwd_port_o    (fwd_port[g]),
         .out_byte_o    (out_byte[g]),
         .out_vld_o     (out_vld[g]),
         .out_last_o    (out_last[g])
      );

      port_tx u_tx
      (
         .clk           (clk),
         .rst_n_i       (rst_n_i),
         .tx_byte_i     (tx_byte[g]),
         .tx_byte_vld_i (tx_byte_vld[g]),
         .tx_en_o       (tx_en_o[g]),
         .tx_nibble_o   (tx_nibble_o[g])
      );
   end

   switch_fabric u_fabric
   (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .fwd_req_i     (fwd_req),
      .fwd_port_i    (fwd_port),
      .out_byte_i    (out_byte),
      .out_vld_i     (out_vld),
      .out_last_i    (out_last),
      .fwd_gnt_o     (fwd_gnt),
      .tx_byte_o     (tx_byte),
      .tx_byte_vld_o (tx_byte_vld)
   );

endmodule

`default_nettype wire

// File: switch_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "switch_defs.svh"

module switch_checker
#(
   parameter int BUF_LEN = 80
)
(
   input  logic                      clk,
   input  logic                      rst_n_i,
   input  logic [`SW_NUM_PORTS-1:0]  tx_en_i,
   input  switch_pkg::nibble_t       tx_nibble_i [`SW_NUM_PORTS]
);

   localparam int N       = `SW_NUM_PORTS;
   localparam int MAX_EXP = 64;

   logic [7:0]          exp_data  [MAX_EXP][BUF_LEN];
   int                  exp_len   [MAX_EXP];
   int                  exp_cnt;
   int                  exp_q     [N][N][$];   // frame ids per output and input
   logic [7:0]          burst_buf [N][BUF_LEN];
   int                  nib_cnt   [N];
   int                  gap_cnt   [N];         // low cycles since last burst
   bit                  seen      [N];
   switch_pkg::nibble_t lo_nib    [N];
   int                  err_cnt;
   int                  frames_ok;

   initial
   begin
      exp_cnt   = 0;
      err_cnt   = 0;
      frames_ok = 0;
   end

   task automatic flag_error(input string msg);
      err_cnt++;
      $display("** Error @ %0t ns: %s", $time, msg);
   endtask

   task automatic expect_frame(input int out_p, input int in_p,
                               input logic [7:0] frm [BUF_LEN], input int len);
      if (exp_cnt >= MAX_EXP)
      begin
         err_cnt++;
         $display("checker: no room left to store the frame from port %0d", in_p);
         return;
      end
      for (int i = 0; i < BUF_LEN; i++)
         exp_data[exp_cnt][i] = frm[i];
      exp_len[exp_cnt] = len;
      exp_q[out_p][in_p].push_back(exp_cnt);
      exp_cnt++;
   endtask

   function automatic bit frame_matches(input int p, input int id, input int len);
      if (exp_len[id] != len)
         return 1'b0;
      for (int i = 0; i < len; i++)
         if (burst_buf[p][i] !== exp_data[id][i])
            return 1'b0;
      return 1'b1;
   endfunction

   function automatic int pending();
      int total;
      total = 0;
      for (int o = 0; o < N; o++)
         for (int i = 0; i < N; i++)
            total += exp_q[o][i].size();
      return total;
   endfunction

   // any input whose head frame matches may own the burst
   task automatic finish_frame(input int p);
      int len;
      int hit;
      len = nib_cnt[p] / 2;
      hit = -1;
      if (nib_cnt[p] % 2 != 0)
         flag_error($sformatf("port %0d burst has an odd nibble count", p));
      for (int i = 0; i < N; i++)
         if (hit < 0 && exp_q[p][i].size() != 0 && frame_matches(p, exp_q[p][i][0], len))
            hit = i;
      if (hit >= 0)
      begin
         void'(exp_q[p][hit].pop_front());
         frames_ok++;
      end
      else
         flag_error($sformatf("port %0d sent a %0d byte frame that matches no expected frame",
                              p, len));
   endtask

   always @(negedge clk)
   begin
      for (int p = 0; p < N; p++)
      begin
         if (!rst_n_i)
         begin
            nib_cnt[p] = 0;
            gap_cnt[p] = 0;
            seen[p]    = 1'b0;
         end
         else if (tx_en_i[p])
         begin
            if (nib_cnt[p] == 0 && seen[p] && gap_cnt[p] < `SW_TX_GAP)
               flag_error($sformatf("port %0d gap of %0d cycles between frames", p, gap_cnt[p]));
            if (nib_cnt[p] % 2 == 0)
               lo_nib[p] = tx_nibble_i[p];
            else if (nib_cnt[p] / 2 < BUF_LEN)
               burst_buf[p][nib_cnt[p] / 2] = {tx_nibble_i[p], lo_nib[p]};
            nib_cnt[p]++;
         end
         else
         begin
            if (nib_cnt[p] != 0)
            begin
               finish_frame(p);   // tx_en fell so the burst is complete
               nib_cnt[p] = 0;
               gap_cnt[p] = 0;
               seen[p]    = 1'b1;
            end
            gap_cnt[p]++;
         end
      end
   end

   task automatic report();
      for (int o = 0; o < N; o++)
         for (int i = 0; i < N; i++)
            if (exp_q[o][i].size() != 0)
            begin
               err_cnt += exp_q[o][i].size();
               $display("** Error @ %0t ns: %0d frames from port %0d to port %0d never came out",
                        $time, exp_q[o][i].size(), i, o);
            end
      $display("checker: %0d frames delivered, %0d errors", frames_ok, err_cnt);
   endtask

endmodule

`default_nettype wire

// File: tb_switch.sv
`timescale 1ns/1ps
`default_nettype none
`include "switch_defs.svh"

module tb_switch;

   localparam int N          = `SW_NUM_PORTS;
   localparam int BUF_LEN    = 80;   // room for oversized frames
   localparam int RND_FRAMES = 4;    // random frames per port
   localparam int DIR_FRAMES = 12;
   localparam int MAX_CYCLES = (DIR_FRAMES + N * RND_FRAMES) * 1000 + 5000;

   logic                clk;
   logic                rst_n;
   logic [N-1:0]        rx_dv;
   switch_pkg::nibble_t rx_nibble [N];
   logic [N-1:0]        tx_en;
   switch_pkg::nibble_t tx_nibble [N];

   integer              seed;
   logic [7:0]          rnd_frm  [N][RND_FRAMES][BUF_LEN];
   int                  rnd_len  [N][RND_FRAMES];
   int                  rnd_idle [N][RND_FRAMES];

   switch_top u_dut
   (
      .clk         (clk),
      .rst_n_i     (rst_n),
      .rx_dv_i     (rx_dv),
      .rx_nibble_i (rx_nibble),
      .tx_en_o     (tx_en),
      .tx_nibble_o (tx_nibble)
   );

   switch_checker #(.BUF_LEN(BUF_LEN)) u_chk
   (
      .clk         (clk),
      .rst_n_i     (rst_n),
      .tx_en_i     (tx_en),
      .tx_nibble_i (tx_nibble)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // 02:00:00:00:00:0N goes to port N-1 and everything else is dropped
   function automatic int route(input int in_p, input logic [7:0] frm [BUF_LEN], input int len);
      logic [39:0] prefix;
      prefix = {frm[0], frm[1], frm[2], frm[3], frm[4]};
      if (len < `SW_MIN_FRAME || len > `SW_MAX_FRAME)
         return -1;
      if (prefix != `SW_MAC_PREFIX)
         return -1;
      if (int'(frm[5]) < 1 || int'(frm[5]) > N || int'(frm[5]) - 1 == in_p)
         return -1;
      return int'(frm[5]) - 1;
   endfunction

   task automatic build_frame(input int dst, input bit bad_prefix,
                              output logic [7:0] frm [BUF_LEN]);
      for (int i = 0; i < BUF_LEN; i++)
         frm[i] = 8'($random(seed));   // payload
      frm[0] = 8'h02;
      frm[1] = 8'h00;
      frm[2] = bad_prefix ? 8'h55 : 8'h00;
      frm[3] = 8'h00;
      frm[4] = 8'h00;
      frm[5] = 8'(dst);
   endtask

   // low nibble first and one nibble per clock
   task automatic send_frame(input int p, input logic [7:0] frm [BUF_LEN], input int len);
      int dst;
      dst = route(p, frm, len);
      if (dst >= 0)
         u_chk.expect_frame(dst, p, frm, len);
      @(posedge clk);
      #1;
      for (int i = 0; i < len; i++)
      begin
         rx_dv[p]     = 1'b1;
         rx_nibble[p] = frm[i][3:0];
         @(posedge clk);
         #1;
         rx_nibble[p] = frm[i][7:4];
         @(posedge clk);
         #1;
      end
      rx_dv[p]     = 1'b0;
      rx_nibble[p] = 4'h0;
   endtask

   // idle time after a frame and then until the model queues are empty
   task automatic wait_drain();
      int cycles;
      cycles = 0;
      repeat (900) @(posedge clk);
      while (u_chk.pending() != 0 && cycles < 8000)
      begin
         @(posedge clk);
         cycles++;
      end
   endtask

   task automatic play_port(input int p);
      logic [7:0] frm [BUF_LEN];
      for (int k = 0; k < RND_FRAMES; k++)
      begin
         for (int i = 0; i < BUF_LEN; i++)
            frm[i] = rnd_frm[p][k][i];
         repeat (rnd_idle[p][k]) @(posedge clk);
         send_frame(p, frm, rnd_len[p][k]);
      end
   endtask

   initial
   begin
      logic [7:0] frm_a [BUF_LEN];
      logic [7:0] frm_b [BUF_LEN];
      seed  = 21252;
      rst_n = 1'b0;
      rx_dv = '0;
      for (int p = 0; p < N; p++)
         rx_nibble[p] = 4'h0;
      // random traffic is drawn up front so the ports play it in a fixed order
      for (int p = 0; p < N; p++)
         for (int k = 0; k < RND_FRAMES; k++)
         begin
            build_frame({$random(seed)} % 8, ({$random(seed)} % 10) == 0, frm_a);
            for (int i = 0; i < BUF_LEN; i++)
               rnd_frm[p][k][i] = frm_a[i];
            rnd_len[p][k]  = 6 + {$random(seed)} % 66;
            rnd_idle[p][k] = 900 + {$random(seed)} % 100;
         end
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;

      build_frame(4, 1'b0, frm_a);   // single frame from port 0 to port 3
      send_frame(0, frm_a, 20);
      wait_drain();

      build_frame(3, 1'b1, frm_a);   // wrong prefix
      send_frame(1, frm_a, 20);
      wait_drain();
      build_frame(0, 1'b0, frm_a);
      send_frame(1, frm_a, 20);
      wait_drain();
      build_frame(7, 1'b0, frm_a);
      send_frame(1, frm_a, 20);
      wait_drain();
      build_frame(2, 1'b0, frm_a);   // own port
      send_frame(1, frm_a, 20);
      wait_drain();
      build_frame(3, 1'b0, frm_a);   // too short
      send_frame(1, frm_a, 5);
      wait_drain();
      build_frame(3, 1'b0, frm_a);   // too long
      send_frame(1, frm_a, 70);
      wait_drain();

      // two inputs into port 5 at once
      build_frame(6, 1'b0, frm_a);
      build_frame(6, 1'b0, frm_b);
      fork
         send_frame(2, frm_a, 20);
         send_frame(4, frm_b, 30);
      join
      wait_drain();

      for (int k = 0; k < 3; k++)
      begin
         build_frame(2, 1'b0, frm_a);
         send_frame(0, frm_a, 10 + 8 * k);
         wait_drain();
      end

      for (int p = 0; p < N; p++)
      begin
         fork
            automatic int pp = p;
            play_port(pp);
         join_none
      end
      wait fork;
      wait_drain();

      u_chk.report();
      if (u_chk.err_cnt == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

   initial
   begin
      repeat (MAX_CYCLES) @(posedge clk);
      $display("watchdog: traffic did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
switch_pkg.sv
port_rx.sv
ingress_buffer.sv
switch_fabric.sv
port_tx.sv
switch_top.sv
switch_checker.sv
tb_switch.sv

// File: run_sim.sh
#!/bin/sh
# build and run the switch testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_switch -o tb_switch_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   echo "Simulation failed"
   exit 1
fi

./obj_dir/tb_switch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
   echo "Simulation failed"
   exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
   exit 0
fi
echo "Simulation failed"
exit 1
